// File: source/soc_pkg.sv
package soc_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int BYTE_EN_W = DATA_W / 8;

    // byte address and data word on the cpu data bus.
    typedef logic [ADDR_W-1:0]    bus_addr_t;
    typedef logic [DATA_W-1:0]    bus_data_t;
    typedef logic [BYTE_EN_W-1:0] byte_en_t;    // bit 0 is the lowest byte.

    localparam int TIMER_OFS_W = 4;
    typedef logic [TIMER_OFS_W-1:0] timer_ofs_t;

    // address map.
    localparam bus_addr_t RAM_BASE   = 32'h0000_0000;
    localparam bus_addr_t TIMER_BASE = 32'h1000_0000;
    localparam bus_addr_t TIMER_SPAN = 32'h0000_0010;    // four word registers.

    // timer register offsets inside the timer region.
    localparam timer_ofs_t TIMER_COUNT_OFS   = 4'h0;
    localparam timer_ofs_t TIMER_COMPARE_OFS = 4'h4;
    localparam timer_ofs_t TIMER_CTRL_OFS    = 4'h8;

    // control/status bits.
    localparam int CTRL_ENABLE_BIT  = 0;
    localparam int CTRL_PENDING_BIT = 1;    // write 1 to clear.

endpackage

// File: source/dbus_decoder.sv
`timescale 1ns/1ns

module dbus_decoder import soc_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 64
) (
    input  bus_addr_t                          dbus_address_i,
    input  logic                               dbus_read_i,
    input  logic                               dbus_write_i,
    input  logic                               rd_accept_i,
    output logic [NUM_BANKS-1:0]               bank_wr_o,
    output logic [NUM_BANKS-1:0]               bank_rd_o,
    output logic [$clog2(BANK_DEPTH)-1:0]      bank_row_o,
    output logic                               timer_wr_o,
    output logic                               timer_rd_o,
    output timer_ofs_t                         timer_ofs_o,
    output logic [$clog2(NUM_BANKS + 2)-1:0]   rd_src_o
);

    localparam int BANK_W     = $clog2(NUM_BANKS);
    localparam int ROW_W      = $clog2(BANK_DEPTH);
    localparam int SRC_W      = $clog2(NUM_BANKS + 2);
    localparam int WORD_SHIFT = $clog2(BYTE_EN_W);

    localparam bus_addr_t RAM_BYTES = bus_addr_t'(NUM_BANKS * BANK_DEPTH * BYTE_EN_W);

    // read source codes: banks 0..NUM_BANKS-1, then timer, then unmapped.
    localparam logic [SRC_W-1:0] SRC_TIMER    = SRC_W'(NUM_BANKS);
    localparam logic [SRC_W-1:0] SRC_UNMAPPED = SRC_W'(NUM_BANKS + 1);

    bus_addr_t         ram_ofs;
    bus_addr_t         timer_rel;
    logic              in_ram;
    logic              in_timer;
    logic              rd_new;
    logic [BANK_W-1:0] bank_idx;

    assign ram_ofs   = dbus_address_i - RAM_BASE;
    assign timer_rel = dbus_address_i - TIMER_BASE;
    assign in_ram    = ram_ofs < RAM_BYTES;
    assign in_timer  = timer_rel < TIMER_SPAN;

    // only the first cycle of a held read reaches the targets.
    assign rd_new = dbus_read_i & ~rd_accept_i;

    // low word-address bits pick the bank, the rest pick the row.
    assign bank_idx   = ram_ofs[WORD_SHIFT +: BANK_W];
    assign bank_row_o = ram_ofs[WORD_SHIFT + BANK_W +: ROW_W];

    always_comb begin
        bank_wr_o = '0;
        bank_rd_o = '0;
        if (in_ram) begin
            bank_wr_o[bank_idx] = dbus_write_i;
            bank_rd_o[bank_idx] = rd_new;
        end
    end

    assign timer_wr_o  = in_timer & dbus_write_i;
    assign timer_rd_o  = in_timer & rd_new;
    assign timer_ofs_o = timer_rel[TIMER_OFS_W-1:0];

    always_comb begin
        if (in_ram) begin
            rd_src_o = SRC_W'(bank_idx);
        end else if (in_timer) begin
            rd_src_o = SRC_TIMER;
        end else begin
            rd_src_o = SRC_UNMAPPED;    // returns zero.
        end
    end

endmodule

// File: source/ram_bank.sv
`timescale 1ns/1ns

module ram_bank import soc_pkg::*; #(
    parameter int BANK_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          bank_wr_i,
    input  logic                          bank_rd_i,
    input  logic [$clog2(BANK_DEPTH)-1:0] row_i,
    input  bus_data_t                     wrdata_i,
    input  byte_en_t                      byteenable_i,
    output bus_data_t                     rddata_o
);

    bus_data_t mem [BANK_DEPTH];

    // byte lanes written independently.
    always_ff @(posedge clk) begin
        if (bank_wr_i) begin
            for (int i = 0; i < BYTE_EN_W; i++) begin
                if (byteenable_i[i]) begin
                    mem[row_i][8*i +: 8] <= wrdata_i[8*i +: 8];
                end
            end
        end
    end

    // word held until the next read strobe.
    always_ff @(posedge clk) begin
        if (bank_rd_i) begin
            rddata_o <= mem[row_i];
        end
    end

endmodule

// File: source/tick_timer.sv
`timescale 1ns/1ns

module tick_timer import soc_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       timer_wr_i,
    input  logic       timer_rd_i,
    input  timer_ofs_t timer_ofs_i,
    input  bus_data_t  wrdata_i,
    output bus_data_t  rddata_o,
    output logic       irq_o
);

    bus_data_t count_q;
    bus_data_t compare_q;
    logic      enable_q;
    logic      pending_q;
    logic      match;
    logic      clr_pending;

    assign match       = enable_q && (count_q == compare_q);
    assign clr_pending = timer_wr_i && (timer_ofs_i == TIMER_CTRL_OFS)
                         && wrdata_i[CTRL_PENDING_BIT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q   <= '0;
            compare_q <= '0;
            enable_q  <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (timer_wr_i && timer_ofs_i == TIMER_COUNT_OFS) begin
                count_q <= wrdata_i;
            end else if (match) begin
                count_q <= '0;    // wrap on compare.
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
            if (timer_wr_i && timer_ofs_i == TIMER_COMPARE_OFS) begin
                compare_q <= wrdata_i;
            end
            if (timer_wr_i && timer_ofs_i == TIMER_CTRL_OFS) begin
                enable_q <= wrdata_i[CTRL_ENABLE_BIT];
            end
            // a match in the clear cycle still sets pending.
            pending_q <= match | (pending_q & ~clr_pending);
        end
    end

    always_ff @(posedge clk) begin
        if (timer_rd_i) begin
            case (timer_ofs_i)
                TIMER_COUNT_OFS:   rddata_o <= count_q;
                TIMER_COMPARE_OFS: rddata_o <= compare_q;
                TIMER_CTRL_OFS: begin
                    rddata_o                   <= '0;
                    rddata_o[CTRL_ENABLE_BIT]  <= enable_q;
                    rddata_o[CTRL_PENDING_BIT] <= pending_q;
                end
                default:           rddata_o <= '0;
            endcase
        end
    end

    assign irq_o = pending_q;

endmodule

// File: source/dbus_return.sv
`timescale 1ns/1ns

module dbus_return import soc_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             dbus_read_i,
    input  logic [$clog2(NUM_BANKS + 2)-1:0] rd_src_i,
    input  logic [NUM_BANKS*DATA_W-1:0]      bank_rddata_i,
    input  bus_data_t                        timer_rddata_i,
    output logic                             rd_accept_o,
    output logic                             dbus_stall_o,
    output bus_data_t                        dbus_rddata_o
);

    localparam int SRC_W = $clog2(NUM_BANKS + 2);

    localparam logic [SRC_W-1:0] SRC_TIMER    = SRC_W'(NUM_BANKS);
    localparam logic [SRC_W-1:0] SRC_UNMAPPED = SRC_W'(NUM_BANKS + 1);

    logic             pending_q;
    logic [SRC_W-1:0] src_q;

    // first cycle of a read stalls, second returns data.
    assign dbus_stall_o = dbus_read_i & ~pending_q;
    assign rd_accept_o  = pending_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_q <= 1'b0;
            src_q     <= SRC_UNMAPPED;
        end else begin
            pending_q <= dbus_stall_o;
            if (dbus_stall_o) begin
                src_q <= rd_src_i;    // latched with the request.
            end
        end
    end

    always_comb begin
        dbus_rddata_o = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (src_q == SRC_W'(b)) begin
                dbus_rddata_o = bank_rddata_i[b*DATA_W +: DATA_W];
            end
        end
        if (src_q == SRC_TIMER) begin
            dbus_rddata_o = timer_rddata_i;
        end
    end

endmodule

// File: source/soc_dbus_top.sv
`timescale 1ns/1ns

module soc_dbus_top import soc_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 64
) (
    input  logic      clk,
    input  logic      reset_i,
    input  bus_addr_t dbus_address_i,
    input  byte_en_t  dbus_byteenable_i,
    input  logic      dbus_read_i,
    input  logic      dbus_write_i,
    input  bus_data_t dbus_wrdata_i,
    output bus_data_t dbus_rddata_o,
    output logic      dbus_stall_o,
    output logic      irq_o
);

    localparam int ROW_W = $clog2(BANK_DEPTH);
    localparam int SRC_W = $clog2(NUM_BANKS + 2);

    logic [NUM_BANKS-1:0]        bank_wr;
    logic [NUM_BANKS-1:0]        bank_rd;
    logic [ROW_W-1:0]            bank_row;
    logic [NUM_BANKS*DATA_W-1:0] bank_rddata;
    logic                        timer_wr;
    logic                        timer_rd;
    timer_ofs_t                  timer_ofs;
    bus_data_t                   timer_rddata;
    logic [SRC_W-1:0]            rd_src;
    logic                        rd_accept;

    dbus_decoder #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_decoder (
        .dbus_address_i (dbus_address_i),
        .dbus_read_i    (dbus_read_i),
        .dbus_write_i   (dbus_write_i),
        .rd_accept_i    (rd_accept),
        .bank_wr_o      (bank_wr),
        .bank_rd_o      (bank_rd),
        .bank_row_o     (bank_row),
        .timer_wr_o     (timer_wr),
        .timer_rd_o     (timer_rd),
        .timer_ofs_o    (timer_ofs),
        .rd_src_o       (rd_src)
    );

    // interleaved banks share row, data and enables.
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        ram_bank #(
            .BANK_DEPTH (BANK_DEPTH)
        ) u_bank (
            .clk          (clk),
            .bank_wr_i    (bank_wr[b]),
            .bank_rd_i    (bank_rd[b]),
            .row_i        (bank_row),
            .wrdata_i     (dbus_wrdata_i),
            .byteenable_i (dbus_byteenable_i),
            .rddata_o     (bank_rddata[b*DATA_W +: DATA_W])
        );
    end

    tick_timer u_timer (
        .clk         (clk),
        .reset_i     (reset_i),
        .timer_wr_i  (timer_wr),
        .timer_rd_i  (timer_rd),
        .timer_ofs_i (timer_ofs),
        .wrdata_i    (dbus_wrdata_i),
        .rddata_o    (timer_rddata),
        .irq_o       (irq_o)
    );

    dbus_return #(
        .NUM_BANKS (NUM_BANKS)
    ) u_return (
        .clk            (clk),
        .reset_i        (reset_i),
        .dbus_read_i    (dbus_read_i),
        .rd_src_i       (rd_src),
        .bank_rddata_i  (bank_rddata),
        .timer_rddata_i (timer_rddata),
        .rd_accept_o    (rd_accept),
        .dbus_stall_o   (dbus_stall_o),
        .dbus_rddata_o  (dbus_rddata_o)
    );

endmodule

// File: verif/soc_dbus_properties.sv
`timescale 1ns/1ns

module soc_dbus_properties (
    input logic clk,
    input logic reset_i,
    input logic read_i,
    input logic write_i,
    input logic stall_i,
    input logic irq_i
);

    int unsigned assert_fails = 0;

    // a read stalls for exactly one cycle.
    a_stall_single: assert property (@(posedge clk) disable iff (reset_i) stall_i |=> !stall_i)
        else begin
            $error("stall high two cycles in a row");
            assert_fails++;
        end

    a_stall_read: assert property (@(posedge clk) disable iff (reset_i) stall_i |-> read_i)
        else begin
            $error("stall high without a read strobe");
            assert_fails++;
        end

    a_write_no_stall: assert property (@(posedge clk) disable iff (reset_i) write_i |-> !stall_i)
        else begin
            $error("write stalled");
            assert_fails++;
        end

    a_irq_reset: assert property (@(posedge clk) reset_i |=> !irq_i)
        else begin
            $error("irq high after reset");
            assert_fails++;
        end

endmodule

bind soc_dbus_top soc_dbus_properties u_props (
    .clk     (clk),
    .reset_i (reset_i),
    .read_i  (dbus_read_i),
    .write_i (dbus_write_i),
    .stall_i (dbus_stall_o),
    .irq_i   (irq_o)
);

// File: verif/soc_dbus_tb.sv
`timescale 1ns/1ns

module tb_soc_dbus import soc_pkg::*; ();

    localparam int NUM_BANKS      = 4;
    localparam int BANK_DEPTH     = 64;
    localparam int RAM_WORDS      = NUM_BANKS * BANK_DEPTH;
    localparam int TIMER_CMP      = 20;
    localparam int NUM_ACCESSES   = RAM_WORDS + 3 * 300 + 40;
    localparam int TIMEOUT_CYCLES = 4 * NUM_ACCESSES + 2 * TIMER_CMP + 200;

    logic      clk = 1'b0;
    logic      reset_i;
    bus_addr_t dbus_address_i;
    byte_en_t  dbus_byteenable_i;
    logic      dbus_read_i;
    logic      dbus_write_i;
    bus_data_t dbus_wrdata_i;
    bus_data_t dbus_rddata_o;
    logic      dbus_stall_o;
    logic      irq_o;

    bus_data_t   ram_model [RAM_WORDS];
    bus_data_t   model_compare = '0;
    logic        model_enable  = 1'b0;
    logic        model_pending = 1'b0;
    logic [15:0] lfsr_q        = 16'd11;
    string       test_name     = "reset";
    bus_data_t   exp_q;
    bus_data_t   last_rd;
    logic        skip_q;
    logic        rd_seen       = 1'b0;
    int          cycle_count   = 0;

    soc_dbus_top #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) DUT (.*);

    always #50 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic in_ram(input bus_addr_t addr);
        return (addr - RAM_BASE) < RAM_WORDS * 4;
    endfunction

    function automatic logic in_timer(input bus_addr_t addr);
        return (addr - TIMER_BASE) < 16;
    endfunction

    // expected read word from the model.
    function automatic bus_data_t expected_word(input bus_addr_t addr);
        bus_data_t w;
        w = '0;
        if (in_ram(addr)) begin
            w = ram_model[(addr - RAM_BASE) >> 2];
        end else if (in_timer(addr)) begin
            case (timer_ofs_t'(addr - TIMER_BASE))
                TIMER_COMPARE_OFS: w = model_compare;
                TIMER_CTRL_OFS:    w[1:0] = {model_pending, model_enable};
                default:           w = '0;    // count is zero while stopped.
            endcase
        end
        return w;
    endfunction

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input byte_en_t be);
        {dbus_read_i, dbus_write_i} = 2'b01;
        {dbus_address_i, dbus_wrdata_i, dbus_byteenable_i} = {addr, data, be};
        if (in_ram(addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) ram_model[(addr - RAM_BASE) >> 2][8*i +: 8] = data[8*i +: 8];
            end
        end else if (addr == TIMER_BASE + TIMER_COMPARE_OFS) begin
            model_compare = data;
        end else if (addr == TIMER_BASE + TIMER_CTRL_OFS) begin
            model_enable = data[0];
            if (data[1]) model_pending = 1'b0;
        end
        @(posedge clk);
        #10;
    endtask

    task automatic bus_read(input bus_addr_t addr);
        {dbus_read_i, dbus_write_i, dbus_address_i} = {2'b10, addr};
        @(negedge clk);
        while (dbus_stall_o) @(negedge clk);
        @(posedge clk);
        #10;
    endtask

    task automatic bus_idle();
        {dbus_read_i, dbus_write_i} = 2'b00;
        @(posedge clk);
        #10;
    endtask

    task automatic wait_irq(output int n);
        {dbus_read_i, dbus_write_i} = 2'b00;
        n = 0;
        @(negedge clk);
        while (!irq_o && n < TIMER_CMP + 5) begin
            @(negedge clk);
            n++;
        end
        check_flag("irq rise", 1'b1, irq_o);
        @(posedge clk);
        #10;
    endtask

    // first read cycle stalls, second carries the data.
    always @(negedge clk) begin
        if (!reset_i && dbus_read_i && !rd_seen) begin
            check_flag({test_name, " stall first"}, 1'b1, dbus_stall_o);
            exp_q   = expected_word(dbus_address_i);
            skip_q  = model_enable && dbus_address_i == TIMER_BASE + TIMER_COUNT_OFS;
            rd_seen = 1'b1;
        end else if (!reset_i && dbus_read_i) begin
            check_flag({test_name, " stall second"}, 1'b0, dbus_stall_o);
            if (!skip_q) check_data(test_name, exp_q, dbus_rddata_o);
            last_rd = dbus_rddata_o;
            rd_seen = 1'b0;
        end else if (dbus_write_i) begin
            check_flag({test_name, " write stall"}, 1'b0, dbus_stall_o);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int        n;
        bus_addr_t a;
        bus_data_t d;
        byte_en_t  be;
        reset_i = 1'b1;
        {dbus_address_i, dbus_byteenable_i, dbus_wrdata_i} = '0;
        {dbus_read_i, dbus_write_i} = 2'b00;
        repeat (8) @(posedge clk);
        #10;
        reset_i   = 1'b0;
        test_name = "after_reset";
        check_flag("reset stall", 1'b0, dbus_stall_o);
        check_flag("reset irq", 1'b0, irq_o);
        bus_read(TIMER_BASE + TIMER_COUNT_OFS);
        bus_read(TIMER_BASE + TIMER_COMPARE_OFS);
        bus_read(TIMER_BASE + TIMER_CTRL_OFS);

        test_name = "fill";
        for (int w = 0; w < RAM_WORDS; w++) begin
            a = RAM_BASE + bus_addr_t'(4 * w);
            bus_write(a, (a * 32'h9E37_79B9) ^ 32'h5A5A_C3C3, 4'hF);
        end

        test_name = "random";
        repeat (300) begin
            a  = RAM_BASE + (rand_bits(8) << 2);
            d  = rand_bits(32);
            be = byte_en_t'(rand_bits(4));
            bus_write(a, d, be);
            if (rand_bits(1)) bus_read(a);
            if (rand_bits(1)) bus_read(RAM_BASE + (rand_bits(8) << 2));
        end

        test_name = "back_to_back";
        for (int b = 0; b < 2 * NUM_BANKS; b++) bus_read(RAM_BASE + 32'h100 + 4 * b);

        test_name = "unmapped";
        bus_write(32'h0000_0400, 32'hDEAD_BEEF, 4'hF);    // would alias row 0 of bank 0.
        bus_write(32'h1000_0010, 32'h0BAD_F00D, 4'hF);
        bus_write(32'hFFFF_FFFC, 32'h1234_5678, 4'hF);
        bus_read(RAM_BASE);
        bus_read(RAM_BASE + 32'h3FC);
        bus_read(32'h0000_0400);
        bus_read(32'h1000_0010);
        bus_read(32'hFFFF_FFFC);

        test_name = "timer";
        bus_write(TIMER_BASE + TIMER_COMPARE_OFS, TIMER_CMP, 4'hF);
        bus_write(TIMER_BASE + TIMER_CTRL_OFS, 32'h1, 4'hF);
        wait_irq(n);
        check_flag("irq not before compare period", 1'b1, n >= TIMER_CMP);
        model_pending = 1'b1;
        bus_read(TIMER_BASE + TIMER_COUNT_OFS);
        check_flag("count below compare", 1'b1, last_rd < TIMER_CMP);
        bus_read(TIMER_BASE + TIMER_CTRL_OFS);
        bus_write(TIMER_BASE + TIMER_CTRL_OFS, 32'h3, 4'hF);
        dbus_write_i = 1'b0;
        @(negedge clk);
        check_flag("irq clear", 1'b0, irq_o);
        @(posedge clk);
        #10;
        wait_irq(n);
        model_pending = 1'b1;
        bus_read(TIMER_BASE + TIMER_CTRL_OFS);
        bus_idle();

        if (DUT.u_props.assert_fails == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("%0d bus protocol assertions failed", DUT.u_props.assert_fails);
            $display("TESTS FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: soc_dbus_top.f
source/soc_pkg.sv
source/dbus_decoder.sv
source/ram_bank.sv
source/tick_timer.sv
source/dbus_return.sv
source/soc_dbus_top.sv
verif/soc_dbus_properties.sv
verif/soc_dbus_tb.sv

// File: Bender.yml
package:
  name: soc_dbus

sources:
  - source/soc_pkg.sv
  - source/dbus_decoder.sv
  - source/ram_bank.sv
  - source/tick_timer.sv
  - source/dbus_return.sv
  - source/soc_dbus_top.sv
  - target: simulation
    files:
      - verif/soc_dbus_properties.sv
      - verif/soc_dbus_tb.sv
